/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - hw

sources:
  - hw/rv_core_pkg.sv
  - hw/rv_regfile.sv
  - hw/rv_alu.sv
  - hw/rv_exec_ctrl.sv
  - hw/rv_perf_counter.sv
  - hw/rv_axil_slave.sv
  - hw/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_sva.sv
      - sim/tb_rv_core.sv

/* flist.f */
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_exec_ctrl.sv
hw/rv_perf_counter.sv
hw/rv_axil_slave.sv
hw/rv_core_top.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

/* hw/rv_alu.sv */
// purely combinational; shifts use the low 6 bits of b as in RV64I.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e  op,
  input  logic [`RV_XLEN-1:0]   a,
  input  logic [`RV_XLEN-1:0]   b,
  output logic [`RV_XLEN-1:0]   y
);

  import rv_core_pkg::*;

  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic                        lt_signed;
  logic                        lt_unsigned;

  assign shamt       = b[$clog2(`RV_XLEN)-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_SLL: begin
        y = a << shamt;
      end
      ALU_SLT: begin
        y = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        y = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SRL: begin
        y = a >> shamt;
      end
      ALU_SRA: begin
        y = $unsigned($signed(a) >>> shamt);  // sign bit fills from the left.
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_PASSB: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

/* hw/rv_axil_slave.sv */
// one write and one read outstanding; INSTR writes stall while busy and every response is OKAY.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_axil_slave (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::axil_req_t req,
  output rv_core_pkg::axil_rsp_t rsp,
  input  logic                   busy,
  input  logic                   illegal_pulse,
  input  logic [`RV_XLEN-1:0]    dbg_data,
  input  logic [`RV_XLEN-1:0]    cycle_cnt,
  input  logic [`RV_XLEN-1:0]    retired_cnt,
  output logic                   issue_valid,
  output logic [31:0]            issue_instr,
  output logic [`RV_REG_AW-1:0]  dbg_addr
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                    bvalid_q;
  logic                    rvalid_q;
  logic [`RV_AXIL_DW-1:0]  rdata_q;
  logic [`RV_AXIL_DW-1:0]  rd_mux;
  logic [`RV_REG_AW-1:0]   regsel_q;
  logic                    illegal_q;
  logic                    wr_instr;
  logic                    wr_go;
  logic                    rd_go;

  // --------------------
  // write channels
  assign wr_instr = req.awaddr == `RV_ADDR_INSTR;
  assign wr_go    = req.awvalid && req.wvalid && !bvalid_q && !(wr_instr && busy);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_go) begin
      bvalid_q <= 1'b1;
    end else if (req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regsel_q <= '0;
    end else if (wr_go && req.awaddr == `RV_ADDR_REGSEL && req.wstrb[0]) begin
      regsel_q <= req.wdata[`RV_REG_AW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      illegal_q <= 1'b0;
    end else if (illegal_pulse) begin
      illegal_q <= 1'b1;  // set wins over a clear in the same cycle.
    end else if (wr_go && req.awaddr == `RV_ADDR_STATUS && req.wstrb[0] && req.wdata[1]) begin
      illegal_q <= 1'b0;
    end
  end

  assign issue_valid = wr_go && wr_instr;
  assign issue_instr = req.wdata;
  assign dbg_addr    = regsel_q;

  // --------------------
  // read channels
  assign rd_go = req.arvalid && !rvalid_q;

  always_comb begin
    case (req.araddr)
      `RV_ADDR_STATUS:  rd_mux = {{(`RV_AXIL_DW-2){1'b0}}, illegal_q, busy};
      `RV_ADDR_REGSEL:  rd_mux = {{(`RV_AXIL_DW-`RV_REG_AW){1'b0}}, regsel_q};
      `RV_ADDR_REG_LO:  rd_mux = dbg_data[`RV_AXIL_DW-1:0];
      `RV_ADDR_REG_HI:  rd_mux = dbg_data[`RV_XLEN-1:`RV_AXIL_DW];
      `RV_ADDR_CYCLE:   rd_mux = cycle_cnt[`RV_AXIL_DW-1:0];
      `RV_ADDR_RETIRED: rd_mux = retired_cnt[`RV_AXIL_DW-1:0];
      default:          rd_mux = '0;  // INSTR and unmapped.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_go) begin
      rvalid_q <= 1'b1;
    end else if (req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      rdata_q <= rd_mux;
    end
  end

  always_comb begin
    rsp.awready = wr_go;
    rsp.wready  = wr_go;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = RESP_OKAY;
    rsp.arready = !rvalid_q;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = RESP_OKAY;
  end

endmodule

/* hw/rv_core_pkg.sv */
// types shared by the RTL and the testbench; the settings header must be on the include path.
`include "rv_core_settings.svh"

package rv_core_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    ALU_PASSB = 4'd10   // used by LUI.
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_DECODE = 2'd1,
    ST_EXEC   = 2'd2,
    ST_WB     = 2'd3
  } ctrl_state_e;

  typedef struct packed {
    alu_op_e                 alu_op;
    logic [`RV_REG_AW-1:0]   rd;
    logic [`RV_REG_AW-1:0]   rs1;
    logic [`RV_REG_AW-1:0]   rs2;
    logic [`RV_XLEN-1:0]     imm;      // already sign-extended.
    logic                    use_imm;
    logic                    legal;
  } dec_t;

  typedef struct packed {
    logic                    wen;
    logic [`RV_REG_AW-1:0]   waddr;
    logic [`RV_XLEN-1:0]     wdata;
  } wb_t;

  // --------------------
  // AXI4-Lite channels
  typedef struct packed {
    logic                      awvalid;
    logic [`RV_AXIL_AW-1:0]    awaddr;
    logic                      wvalid;
    logic [`RV_AXIL_DW-1:0]    wdata;
    logic [`RV_AXIL_DW/8-1:0]  wstrb;
    logic                      bready;
    logic                      arvalid;
    logic [`RV_AXIL_AW-1:0]    araddr;
    logic                      rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`RV_AXIL_DW-1:0]    rdata;
    logic [1:0]                rresp;
  } axil_rsp_t;

endpackage

/* hw/rv_core_settings.svh */
// widths are fixed by RV64I and the register map assumes 32-bit aligned AXI4-Lite accesses.
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// --------------------
// datapath
`define RV_XLEN     64
`define RV_NREGS    32
`define RV_REG_AW   $clog2(`RV_NREGS)

// --------------------
// AXI4-Lite port
`define RV_AXIL_AW  8
`define RV_AXIL_DW  32

// register map, byte offsets
`define RV_ADDR_INSTR    8'h00  // write-only.
`define RV_ADDR_STATUS   8'h04  // bit 0 busy, bit 1 illegal (write 1 to clear).
`define RV_ADDR_REGSEL   8'h08
`define RV_ADDR_REG_LO   8'h0C
`define RV_ADDR_REG_HI   8'h10
`define RV_ADDR_CYCLE    8'h14
`define RV_ADDR_RETIRED  8'h18

`endif

/* hw/rv_core_top.sv */
// host sees a single AXI4-Lite slave port; no fetch, one instruction in flight.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::axil_req_t req,
  output rv_core_pkg::axil_rsp_t rsp
);

  import rv_core_pkg::*;

  logic                   issue_valid;
  logic [31:0]            issue_instr;
  logic                   busy;
  logic                   retire;
  logic                   illegal_pulse;
  logic [`RV_REG_AW-1:0]  raddr1;
  logic [`RV_REG_AW-1:0]  raddr2;
  logic [`RV_REG_AW-1:0]  dbg_addr;
  logic                   ren1;
  logic                   ren2;
  logic [`RV_XLEN-1:0]    rdata1;
  logic [`RV_XLEN-1:0]    rdata2;
  logic [`RV_XLEN-1:0]    dbg_data;
  alu_op_e                alu_op;
  logic [`RV_XLEN-1:0]    alu_a;
  logic [`RV_XLEN-1:0]    alu_b;
  logic [`RV_XLEN-1:0]    alu_y;
  wb_t                    wb;
  logic [`RV_XLEN-1:0]    cycle_cnt;
  logic [`RV_XLEN-1:0]    retired_cnt;

  rv_axil_slave i_axil_slave (
    .clk, .rst_n, .req, .rsp,
    .busy, .illegal_pulse, .dbg_data, .cycle_cnt, .retired_cnt,
    .issue_valid, .issue_instr, .dbg_addr
  );

  rv_exec_ctrl i_exec_ctrl (
    .clk, .rst_n, .issue_valid, .issue_instr,
    .rdata1, .rdata2, .alu_y,
    .busy, .raddr1, .raddr2, .ren1, .ren2,
    .alu_op, .alu_a, .alu_b, .wb, .retire, .illegal_pulse
  );

  rv_regfile i_regfile (
    .clk, .rst_n, .wb, .raddr1, .raddr2, .dbg_addr, .ren1, .ren2,
    .rdata1, .rdata2, .dbg_data
  );

  rv_alu i_alu (
    .op (alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  rv_perf_counter i_perf_counter (
    .clk, .rst_n, .retire, .cycle_cnt, .retired_cnt
  );

endmodule

/* hw/rv_exec_ctrl.sv */
// one instruction at a time; issue_valid is only honoured in ST_IDLE, write-back lands 3 cycles later.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_exec_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   issue_valid,
  input  logic [31:0]            issue_instr,
  input  logic [`RV_XLEN-1:0]    rdata1,
  input  logic [`RV_XLEN-1:0]    rdata2,
  input  logic [`RV_XLEN-1:0]    alu_y,
  output logic                   busy,
  output logic [`RV_REG_AW-1:0]  raddr1,
  output logic [`RV_REG_AW-1:0]  raddr2,
  output logic                   ren1,
  output logic                   ren2,
  output rv_core_pkg::alu_op_e   alu_op,
  output logic [`RV_XLEN-1:0]    alu_a,
  output logic [`RV_XLEN-1:0]    alu_b,
  output rv_core_pkg::wb_t       wb,
  output logic                   retire,
  output logic                   illegal_pulse
);

  import rv_core_pkg::*;

  ctrl_state_e          state_q;
  dec_t                 dec_d;
  dec_t                 dec_q;
  opcode_e              opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`RV_XLEN-1:0]  op_a_q;
  logic [`RV_XLEN-1:0]  op_b_q;
  logic [`RV_XLEN-1:0]  res_q;

  assign opcode = opcode_e'(issue_instr[6:0]);
  assign funct3 = issue_instr[14:12];
  assign funct7 = issue_instr[31:25];

  // --------------------
  // decode
  always_comb begin
    dec_d.rd      = issue_instr[11:7];
    dec_d.rs1     = issue_instr[19:15];
    dec_d.rs2     = issue_instr[24:20];
    dec_d.imm     = {{(`RV_XLEN-12){issue_instr[31]}}, issue_instr[31:20]};  // I format.
    dec_d.use_imm = 1'b1;
    dec_d.alu_op  = ALU_ADD;
    dec_d.legal   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec_d.rs1    = '0;
        dec_d.imm    = {{(`RV_XLEN-32){issue_instr[31]}}, issue_instr[31:12], 12'b0};
        dec_d.alu_op = ALU_PASSB;
        dec_d.legal  = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_d.legal = 1'b1;
        case (funct3)
          3'b000: dec_d.alu_op = ALU_ADD;
          3'b010: dec_d.alu_op = ALU_SLT;
          3'b011: dec_d.alu_op = ALU_SLTU;
          3'b100: dec_d.alu_op = ALU_XOR;
          3'b110: dec_d.alu_op = ALU_OR;
          3'b111: dec_d.alu_op = ALU_AND;
          3'b001: begin
            dec_d.alu_op = ALU_SLL;
            dec_d.legal  = issue_instr[31:26] == 6'b000000;  // 6-bit shamt.
          end
          default: begin
            dec_d.alu_op = issue_instr[30] ? ALU_SRA : ALU_SRL;
            dec_d.legal  = {issue_instr[31], issue_instr[29:26]} == 5'b00000;
          end
        endcase
      end
      OPC_OP: begin
        dec_d.use_imm = 1'b0;
        dec_d.legal   = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_d.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec_d.alu_op = ALU_SUB;
          {7'b0000000, 3'b001}: dec_d.alu_op = ALU_SLL;
          {7'b0000000, 3'b010}: dec_d.alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: dec_d.alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: dec_d.alu_op = ALU_XOR;
          {7'b0000000, 3'b101}: dec_d.alu_op = ALU_SRL;
          {7'b0100000, 3'b101}: dec_d.alu_op = ALU_SRA;
          {7'b0000000, 3'b110}: dec_d.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec_d.alu_op = ALU_AND;
          default:              dec_d.legal  = 1'b0;
        endcase
      end
      default: begin
        dec_d.legal = 1'b0;
      end
    endcase
  end

  // --------------------
  // sequencing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (issue_valid) state_q <= ST_DECODE;
        ST_DECODE: state_q <= ST_EXEC;
        ST_EXEC:   state_q <= ST_WB;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && issue_valid) begin
      dec_q <= dec_d;
    end
    if (state_q == ST_DECODE) begin
      op_a_q <= rdata1;
      op_b_q <= dec_q.use_imm ? dec_q.imm : rdata2;
    end
    if (state_q == ST_EXEC) begin
      res_q <= alu_y;
    end
  end

  assign busy   = state_q != ST_IDLE;
  assign raddr1 = dec_q.rs1;
  assign raddr2 = dec_q.rs2;
  assign ren1   = state_q == ST_DECODE && dec_q.legal;
  assign ren2   = state_q == ST_DECODE && dec_q.legal && !dec_q.use_imm;
  assign alu_op = dec_q.alu_op;
  assign alu_a  = op_a_q;
  assign alu_b  = op_b_q;

  assign wb.wen   = state_q == ST_WB && dec_q.legal;
  assign wb.waddr = dec_q.rd;
  assign wb.wdata = res_q;

  assign retire        = state_q == ST_WB && dec_q.legal;
  assign illegal_pulse = state_q == ST_WB && !dec_q.legal;

endmodule

/* hw/rv_perf_counter.sv */
// 64-bit counters wrap silently; only the low 32 bits are visible on the bus.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_perf_counter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 retire,
  output logic [`RV_XLEN-1:0]  cycle_cnt,
  output logic [`RV_XLEN-1:0]  retired_cnt
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;  // free running.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired_cnt <= '0;
    end else if (retire) begin
      retired_cnt <= retired_cnt + 1'b1;
    end
  end

endmodule

/* hw/rv_regfile.sv */
// reads are combinational and return zero when disabled; x0 ignores writes.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::wb_t       wb,
  input  logic [`RV_REG_AW-1:0]  raddr1,
  input  logic [`RV_REG_AW-1:0]  raddr2,
  input  logic [`RV_REG_AW-1:0]  dbg_addr,
  input  logic                   ren1,
  input  logic                   ren2,
  output logic [`RV_XLEN-1:0]    rdata1,
  output logic [`RV_XLEN-1:0]    rdata2,
  output logic [`RV_XLEN-1:0]    dbg_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  // --------------------
  // read ports
  assign rdata1   = ren1 ? regs[raddr1] : '0;
  assign rdata2   = ren2 ? regs[raddr2] : '0;
  assign dbg_data = regs[dbg_addr];  // host readback, always enabled.

endmodule

/* sim/rv_core_stimulus.txt */
// kind arg expected. kinds: 1 issue, 2 issue without gap, 3 register check (arg = index),
// 4 status check (bit 0 busy, bit 1 illegal), 5 retired count, 6 clear illegal, 7 cycle, 0 end.
1 123450B7 0  // lui x1, 0x12345
1 67808093 0  // addi x1, x1, 0x678
1 80000137 0  // lui x2, 0x80000
1 FFF00193 0  // addi x3, x0, -1
1 80000213 0  // addi x4, x0, -2048
3 1 0000000012345678
3 2 FFFFFFFF80000000
3 3 FFFFFFFFFFFFFFFF
3 4 FFFFFFFFFFFFF800
1 003082B3 0  // add x5, x1, x3
1 40120333 0  // sub x6, x4, x1
1 001123B3 0  // slt x7, x2, x1
1 00113433 0  // sltu x8, x2, x1
1 0020B4B3 0  // sltu x9, x1, x2
3 5 0000000012345677
3 6 FFFFFFFFEDCBA188
3 7 0000000000000001
3 8 0000000000000000
3 9 0000000000000001
1 02400513 0  // addi x10, x0, 36
1 02009613 0  // slli x12, x1, 32
1 40835693 0  // srai x13, x6, 8
1 00835713 0  // srli x14, x6, 8
1 40A157B3 0  // sra x15, x2, x10
1 00A15833 0  // srl x16, x2, x10
1 00A098B3 0  // sll x17, x1, x10
3 C 1234567800000000
3 D FFFFFFFFFFEDCBA1
3 E 00FFFFFFFFEDCBA1
3 F FFFFFFFFFFFFFFFF
3 10 000000000FFFFFFF
3 11 2345678000000000
1 0030C933 0  // xor x18, x1, x3
1 0040E9B3 0  // or x19, x1, x4
1 0040FA33 0  // and x20, x1, x4
1 FFF22A93 0  // slti x21, x4, -1
3 12 FFFFFFFFEDCBA987
3 13 FFFFFFFFFFFFFE78
3 14 0000000012345000
3 15 0000000000000001
1 00508013 0  // addi x0, x1, 5
3 0 0
3 1 0000000012345678
3 B 0
5 0 16
4 0 0
1 023080B3 0  // mul x1, x1, x3 is not supported
4 0 2
3 1 0000000012345678
5 0 16
6 0 0
4 0 0
7 0 0
2 00300D13 0  // addi x26, x0, 3
2 01AD0DB3 0  // add x27, x26, x26
2 01AD8DB3 0  // add x27, x27, x26
2 01BD8DB3 0  // add x27, x27, x27
2 01AD8DB3 0  // add x27, x27, x26
3 1B 15
3 1A 3
5 0 1B
0 0 0

/* sim/rv_core_sva.sv */
// bound into rv_core_top; checks AXI4-Lite valid/ready rules, issue gating, FSM order and x0.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module rv_core_sva (
  input logic                      clk,
  input logic                      rst_n,
  input rv_core_pkg::axil_req_t    req,
  input rv_core_pkg::axil_rsp_t    rsp,
  input logic                      issue_valid,
  input logic                      busy,
  input rv_core_pkg::ctrl_state_e  state,
  input logic [`RV_XLEN-1:0]       x0
);

  import rv_core_pkg::*;

  int unsigned fail_cnt = 0;  // polled by the testbench.

  task automatic flag_failure(input string what);
    $error("%s", what);
    fail_cnt++;
  endtask

  property hold_p(logic valid, logic ready);
    @(posedge clk) disable iff (!rst_n) valid && !ready |=> valid;
  endproperty

  // --------------------
  // AXI4-Lite channels
  a_aw_hold: assert property (hold_p(req.awvalid, rsp.awready))
    else flag_failure("awvalid dropped before awready.");
  a_w_hold: assert property (hold_p(req.wvalid, rsp.wready))
    else flag_failure("wvalid dropped before wready.");
  a_b_hold: assert property (hold_p(rsp.bvalid, req.bready))
    else flag_failure("bvalid dropped before bready.");
  a_ar_hold: assert property (hold_p(req.arvalid, rsp.arready))
    else flag_failure("arvalid dropped before arready.");
  a_r_hold: assert property (hold_p(rsp.rvalid, req.rready))
    else flag_failure("rvalid dropped before rready.");

  // --------------------
  // controller
  // busy covers decode, exec and write-back, and nothing issues in that window.
  a_no_issue_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
      issue_valid |=> (busy && !issue_valid) [*3] ##1 !busy)
    else flag_failure("issue during busy or busy window not three cycles.");
  a_wb_to_idle: assert property (
    @(posedge clk) disable iff (!rst_n) state == ST_WB |=> state == ST_IDLE)
    else flag_failure("write-back not followed by idle.");
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) x0 == '0)
    else flag_failure("x0 is not zero.");

endmodule

/* sim/tb_rv_core.sv */
// run from the project root with hw/ on the include path; the stimulus file is read relative to it.
`timescale 1ns/1ns
`include "rv_core_settings.svh"

module tb_rv_core;

  import rv_core_pkg::*;

  localparam int RESET_CYCLES      = 10;
  localparam int CYCLES_PER_RECORD = 60;
  localparam int HS_LIMIT          = 32;   // cycles a single handshake may take.
  localparam int POLL_LIMIT        = 16;
  localparam int STIM_WORDS        = 384;  // three words per record.

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------
  // record kinds
  localparam int REC_END     = 0;
  localparam int REC_ISSUE   = 1;
  localparam int REC_BURST   = 2;  // issue with no idle gap.
  localparam int REC_REG     = 3;
  localparam int REC_STATUS  = 4;
  localparam int REC_RETIRED = 5;
  localparam int REC_CLEAR   = 6;
  localparam int REC_CYCLE   = 7;

  logic                clk;
  logic                rst_n;
  axil_req_t           req;
  axil_rsp_t           rsp;
  logic [`RV_XLEN-1:0] stim [STIM_WORDS];
  logic [31:0]         rng_state;
  int                  run_cycles;
  int                  cycle_limit;

  rv_core_top i_dut (
    .clk,
    .rst_n,
    .req,
    .rsp
  );

  bind rv_core_top rv_core_sva i_sva (
    .clk,
    .rst_n,
    .req,
    .rsp,
    .issue_valid,
    .busy,
    .state (i_exec_ctrl.state_q),
    .x0    (i_regfile.regs[0])
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // helpers
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic idle_gap();
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) begin  // 0 to 3 idle cycles.
      @(posedge clk);
      #2;
    end
  endtask

  // all bus tasks start and end 2 ns after a rising edge.
  task automatic write_word(input logic [`RV_AXIL_AW-1:0] addr,
                            input logic [`RV_AXIL_DW-1:0] data);
    int waited;
    waited = 0;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    req.bready  = 1'b1;
    @(negedge clk);
    while (!rsp.awready) begin  // INSTR stalls here while busy.
      waited++;
      if (waited > HS_LIMIT) stop_with_failure("AXI4-Lite write was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    waited      = 0;
    while (!rsp.bvalid) begin
      waited++;
      if (waited > HS_LIMIT) stop_with_failure("AXI4-Lite write response never arrived");
      @(posedge clk);
      #2;
    end
    check_resp("bresp", rsp.bresp, RESP_OKAY);
    @(posedge clk);
    #2;
    req.bready = 1'b0;
  endtask

  task automatic read_word(input logic [`RV_AXIL_AW-1:0] addr,
                           output logic [`RV_AXIL_DW-1:0] data);
    int waited;
    waited      = 0;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b1;
    @(negedge clk);
    while (!rsp.arready) begin
      waited++;
      if (waited > HS_LIMIT) stop_with_failure("AXI4-Lite read address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req.arvalid = 1'b0;
    waited      = 0;
    while (!rsp.rvalid) begin
      waited++;
      if (waited > HS_LIMIT) stop_with_failure("AXI4-Lite read data never arrived");
      @(posedge clk);
      #2;
    end
    data = rsp.rdata;
    check_resp("rresp", rsp.rresp, RESP_OKAY);
    @(posedge clk);
    #2;
    req.rready = 1'b0;
  endtask

  task automatic wait_idle();
    logic [`RV_AXIL_DW-1:0] st;
    int polls;
    polls = 0;
    idle_gap();
    read_word(`RV_ADDR_STATUS, st);
    while (st[0]) begin
      polls++;
      if (polls > POLL_LIMIT) stop_with_failure("controller stayed busy");
      idle_gap();
      read_word(`RV_ADDR_STATUS, st);
    end
  endtask

  task automatic read_back_reg(input logic [`RV_REG_AW-1:0] idx,
                               output logic [`RV_XLEN-1:0] value);
    logic [`RV_AXIL_DW-1:0] lo;
    logic [`RV_AXIL_DW-1:0] hi;
    idle_gap();
    write_word(`RV_ADDR_REGSEL, {{(`RV_AXIL_DW-`RV_REG_AW){1'b0}}, idx});
    idle_gap();
    read_word(`RV_ADDR_REG_LO, lo);
    idle_gap();
    read_word(`RV_ADDR_REG_HI, hi);
    value = {hi, lo};
  endtask

  // --------------------
  // compare tasks
  task automatic check_reg(input logic [`RV_REG_AW-1:0] idx,
                           input logic [`RV_XLEN-1:0] got,
                           input logic [`RV_XLEN-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH t=%0t ns x%0d got %h expected %h",
                                  $time, idx, got, exp));
    end
  endtask

  task automatic check_status(input logic got_busy, input logic got_illegal,
                              input logic exp_busy, input logic exp_illegal);
    if (got_busy !== exp_busy) begin
      stop_with_failure($sformatf("MISMATCH t=%0t ns status.busy got %b expected %b",
                                  $time, got_busy, exp_busy));
    end
    if (got_illegal !== exp_illegal) begin
      stop_with_failure($sformatf("MISMATCH t=%0t ns status.illegal got %b expected %b",
                                  $time, got_illegal, exp_illegal));
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH t=%0t ns %s got %0d expected %0d",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH t=%0t ns %s got %b expected %b",
                                  $time, name, got, exp));
    end
  endtask

  // --------------------
  // watchdog
  always @(posedge clk) begin
    run_cycles++;
    if (cycle_limit != 0 && run_cycles > cycle_limit) begin
      stop_with_failure($sformatf("timeout after %0d cycles", run_cycles));
    end
    if (i_dut.i_sva.fail_cnt != 0) stop_with_failure("a bound assertion failed");
  end

  initial begin
    logic [`RV_XLEN-1:0]    kind;
    logic [`RV_XLEN-1:0]    arg;
    logic [`RV_XLEN-1:0]    expv;
    logic [`RV_XLEN-1:0]    got;
    logic [`RV_AXIL_DW-1:0] word;
    logic [`RV_AXIL_DW-1:0] first_cnt;
    int                     n_rec;
    rst_n       = 1'b0;
    req         = '0;
    rng_state   = 32'd85;
    run_cycles  = 0;
    cycle_limit = 0;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("sim/rv_core_stimulus.txt", stim);
    n_rec = 0;
    while (3 * n_rec < STIM_WORDS && stim[3 * n_rec] != REC_END) begin
      n_rec++;
    end
    if (n_rec == 0) stop_with_failure("stimulus file holds no records");
    cycle_limit = CYCLES_PER_RECORD * n_rec + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int r = 0; r < n_rec; r++) begin
      kind = stim[3 * r];
      arg  = stim[3 * r + 1];
      expv = stim[3 * r + 2];
      case (kind)
        REC_ISSUE: begin
          idle_gap();
          write_word(`RV_ADDR_INSTR, arg[31:0]);
        end
        REC_BURST: begin
          write_word(`RV_ADDR_INSTR, arg[31:0]);
        end
        REC_REG: begin
          wait_idle();
          read_back_reg(arg[`RV_REG_AW-1:0], got);
          check_reg(arg[`RV_REG_AW-1:0], got, expv);
        end
        REC_STATUS: begin
          wait_idle();
          idle_gap();
          read_word(`RV_ADDR_STATUS, word);
          check_status(word[0], word[1], expv[0], expv[1]);
        end
        REC_RETIRED: begin
          wait_idle();
          idle_gap();
          read_word(`RV_ADDR_RETIRED, word);
          check_count("retired_cnt", word, expv[31:0]);
        end
        REC_CLEAR: begin
          wait_idle();
          idle_gap();
          write_word(`RV_ADDR_STATUS, 32'h2);  // write 1 to the illegal bit.
        end
        REC_CYCLE: begin
          idle_gap();
          read_word(`RV_ADDR_CYCLE, first_cnt);
          idle_gap();
          read_word(`RV_ADDR_CYCLE, word);
          if (word <= first_cnt) stop_with_failure("cycle count did not increase between reads");
        end
        default: begin
          stop_with_failure($sformatf("unknown record kind %0d in stimulus file", kind));
        end
      endcase
    end
    if (i_dut.i_sva.fail_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1);
    end
  end

endmodule
